/* all.f */
cpu_pkg.sv
stage_if.sv
count_bit.sv
instr_decode.sv
instr_exec.sv
exec_result.sv
cpu_exec_top.sv
tb_checker.sv
tb_cpu_exec.sv

/* Makefile */
TOP = tb_cpu_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_cpu_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_exec;

	localparam logic [19*6-1:0] FN_LIST = {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
		6'h09, 6'h0a, 6'h0b, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b};
	localparam logic [9*6-1:0] OPC_LIST = {6'h03, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
		6'h0d, 6'h0e, 6'h0f};
	localparam logic [8*6-1:0] MEM_OPC = {6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28,
		6'h29, 6'h2b};
	localparam logic [5*6-1:0] MIS_OPC = {6'h21, 6'h25, 6'h29, 6'h23, 6'h2b};
	localparam logic [6*6-1:0] TRAP_FN = {6'h30, 6'h31, 6'h32, 6'h33, 6'h34, 6'h36};
	localparam logic [6*5-1:0] TRAP_RT = {5'h08, 5'h09, 5'h0a, 5'h0b, 5'h0c, 5'h0e};

	logic        clk;
	logic        arst_n;
	logic        flush;
	logic        in_valid;
	logic [31:0] in_pc;
	logic [31:0] in_instr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_result;
	logic        out_wb_en;
	logic [4:0]  out_wb_reg;
	logic        mem_read;
	logic        mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_be;
	logic        ex_valid;
	logic [4:0]  ex_code;
	logic [31:0] ex_badvaddr;
	int          err_count;
	int          check_count;
	int          last_err;
	int          last_checks;
	logic [31:0] next_pc;
	logic        timed_out;

	cpu_exec_top UUT (.*);

	tb_checker u_check (.*);

	always #4 clk = ~clk;

	// short values and long runs of ones for the counters, zero for the moves
	function automatic logic [31:0] operand();
		logic [31:0] r;
		logic [31:0] s;
		r = $urandom;
		s = $urandom;
		case (s[1:0])
			2'd0: return r >> s[6:2];
			2'd1: return ~(r >> s[6:2]);
			2'd2: return r & {32{s[7]}};
			default: return r;
		endcase
	endfunction

	function automatic logic [31:0] alu_instr();
		logic [31:0] r;
		logic [31:0] k;
		r = $urandom;
		k = $urandom % 30;
		if (k < 19) begin
			return {6'h00, r[25:6], FN_LIST[k * 6 +: 6]};
		end else if (k < 28) begin
			return {OPC_LIST[(k - 19) * 6 +: 6], r[25:0]};
		end
		return {6'h1c, r[25:6], (k == 28) ? 6'h20 : 6'h21};
	endfunction

	task automatic issue(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
		input logic fl);
		@(negedge clk);
		in_valid = 1'b1;
		in_instr = instr;
		rs_val   = a;
		rt_val   = b;
		flush    = fl;
		in_pc    = next_pc;
		next_pc  = next_pc + 32'd4;
	endtask

	// rs is adjusted so the effective address ends in low
	task automatic issue_mem(input logic [5:0] opc, input logic [1:0] low, input logic fl);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] ea;
		r  = $urandom;
		a  = $urandom;
		ea = a + {{16{r[15]}}, r[15:0]};
		a  = a - {30'b0, ea[1:0]} + {30'b0, low};
		issue({opc, r[25:0]}, a, operand(), fl);
	endtask

	task automatic wait_idle(input string name);
		int n;
		n = 0;
		@(negedge clk);
		in_valid = 1'b0;
		flush    = 1'b0;
		while (out_valid !== 1'b0 && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (out_valid !== 1'b0) begin
			timed_out = 1'b1;
			$display("timeout in %s: out_valid still high after %0d idle cycles", name, n);
		end
		@(negedge clk);
	endtask

	task automatic report_test(input string name);
		$display("test %-14s checks %0d errors %0d", name, check_count - last_checks,
			err_count - last_err);
		last_checks = check_count;
		last_err    = err_count;
	endtask

	task automatic alu_test(input int count);
		if (timed_out) return;
		for (int i = 0; i < count; i++) begin
			issue(alu_instr(), operand(), operand(), 1'b0);
		end
		wait_idle("alu_random");
	endtask

	task automatic mem_test(input logic misaligned, input int count);
		logic [31:0] r;
		logic [5:0]  opc;
		logic [1:0]  low;
		if (timed_out) return;
		for (int i = 0; i < count; i++) begin
			r = $urandom;
			if (misaligned) begin
				opc = MIS_OPC[(r % 5) * 6 +: 6];
			end else begin
				opc = MEM_OPC[r[2:0] * 6 +: 6];
			end
			case (opc[1:0])
				2'b00: low = r[9:8];
				2'b01: low = {r[9], misaligned};
				default: low = misaligned ? ((r[9:8] == 2'b00) ? 2'b01 : r[9:8]) : 2'b00;
			endcase
			issue_mem(opc, low, 1'b0);
		end
		wait_idle("mem");
	endtask

	task automatic exc_test(input int count);
		logic [31:0] r;
		logic [31:0] a;
		if (timed_out) return;
		// signed overflow next to its unsigned twin
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20}, 32'h7fff_ffff, 32'h1, 1'b0);
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21}, 32'h7fff_ffff, 32'h1, 1'b0);
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h22}, 32'h8000_0000, 32'h1, 1'b0);
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h23}, 32'h8000_0000, 32'h1, 1'b0);
		issue({6'h08, 5'd1, 5'd2, 16'h0001}, 32'h7fff_ffff, 32'h0, 1'b0);
		issue({6'h08, 5'd1, 5'd2, 16'h8000}, 32'h8000_0000, 32'h0, 1'b0);
		issue({6'h09, 5'd1, 5'd2, 16'h0001}, 32'h7fff_ffff, 32'h0, 1'b0);
		issue({6'h00, 20'h0_1234, 6'h0d}, 32'h0, 32'h0, 1'b0);
		issue({6'h00, 20'h0_0000, 6'h0c}, 32'h0, 32'h0, 1'b0);
		issue({6'h3f, 26'h0}, 32'h0, 32'h0, 1'b0);
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h01}, 32'h0, 32'h0, 1'b0);
		issue({6'h01, 5'd1, 5'h00, 16'h0010}, 32'h0, 32'h0, 1'b0);
		// traps, half of them with equal operands
		for (int i = 0; i < count; i++) begin
			r = $urandom;
			a = operand();
			if (r[31]) begin
				issue({6'h00, 5'd4, 5'd5, 10'd0, TRAP_FN[(r % 6) * 6 +: 6]}, a,
					r[30] ? a : operand(), 1'b0);
			end else begin
				if (r[30]) begin
					a = {{16{r[15]}}, r[15:0]};
				end
				issue({6'h01, 5'd4, TRAP_RT[(r % 6) * 5 +: 5], r[15:0]}, a, operand(), 1'b0);
			end
		end
		wait_idle("exceptions");
	endtask

	task automatic burst_test(input int count);
		logic [31:0] r;
		if (timed_out) return;
		for (int i = 0; i < count; i++) begin
			r = $urandom;
			if (r[2:0] == 3'd0) begin
				issue_mem(MEM_OPC[r[6:4] * 6 +: 6], 2'b00, r[9:8] == 2'b00);
			end else begin
				issue(alu_instr(), operand(), operand(), r[9:8] == 2'b00);
			end
		end
		wait_idle("burst_flush");
	endtask

	task automatic idle_test(input int cycles);
		if (timed_out) return;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			in_valid = 1'b0;
			flush    = 1'b0;
			in_instr = $urandom;
			rs_val   = $urandom;
			rt_val   = $urandom;
		end
		wait_idle("idle");
	endtask

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		flush       = 1'b0;
		in_valid    = 1'b0;
		in_pc       = 32'h0;
		in_instr    = 32'h0;
		rs_val      = 32'h0;
		rt_val      = 32'h0;
		next_pc     = 32'h0040_0000;
		timed_out   = 1'b0;
		last_err    = 0;
		last_checks = 0;
		void'($urandom(32'h6470_f9e1));
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		wait_idle("reset");
		report_test("reset");
		alu_test(400);
		report_test("alu_random");
		mem_test(1'b0, 200);
		report_test("mem_aligned");
		mem_test(1'b1, 100);
		report_test("mem_misaligned");
		exc_test(60);
		report_test("exceptions");
		burst_test(200);
		report_test("burst_flush");
		idle_test(20);
		report_test("idle");
		$display("total checks %0d errors %0d", check_count, err_count);
		if (err_count == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        flush,
	input  logic        in_valid,
	input  logic [31:0] in_pc,
	input  logic [31:0] in_instr,
	input  logic [31:0] rs_val,
	input  logic [31:0] rt_val,
	input  logic        out_valid,
	input  logic [31:0] out_pc,
	input  logic [31:0] out_result,
	input  logic        out_wb_en,
	input  logic [4:0]  out_wb_reg,
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_be,
	input  logic        ex_valid,
	input  logic [4:0]  ex_code,
	input  logic [31:0] ex_badvaddr,
	output int          err_count,
	output int          check_count
);

	// inputs captured at the previous rising edge
	logic        c_valid;
	logic        c_flush;
	logic [31:0] c_pc;
	logic [31:0] c_instr;
	logic [31:0] c_rs;
	logic [31:0] c_rt;

	function automatic void predict(
		input  logic [31:0] iw,
		input  logic [31:0] pc,
		input  logic [31:0] rs,
		input  logic [31:0] rt_reg,
		output logic [31:0] res,
		output logic        wb,
		output logic [4:0]  wreg,
		output logic        rd_en,
		output logic        wr_en,
		output logic [31:0] addr,
		output logic [31:0] wdata,
		output logic [3:0]  be,
		output logic        ex,
		output logic [4:0]  code
	);
		logic [5:0]         opc;
		logic [5:0]         fn;
		logic [4:0]         sh;
		logic [31:0]        simm;
		logic [31:0]        rt;
		logic signed [32:0] wide;
		logic               trap;
		logic               mov_fail;
		logic               misal;
		logic               is_ld;
		logic               is_st;
		int                 n;
		cpu_pkg::oper_t     op;
		opc  = iw[31:26];
		fn   = iw[5:0];
		sh   = iw[10:6];
		simm = {{16{iw[15]}}, iw[15:0]};
		op   = cpu_pkg::OP_INVALID;
		case (opc)
			6'h00: begin
				case (fn)
					6'h00: op = cpu_pkg::OP_SLL;
					6'h02: op = cpu_pkg::OP_SRL;
					6'h03: op = cpu_pkg::OP_SRA;
					6'h04: op = cpu_pkg::OP_SLLV;
					6'h06: op = cpu_pkg::OP_SRLV;
					6'h07: op = cpu_pkg::OP_SRAV;
					6'h09: op = cpu_pkg::OP_JALR;
					6'h0a: op = cpu_pkg::OP_MOVZ;
					6'h0b: op = cpu_pkg::OP_MOVN;
					6'h0c: op = cpu_pkg::OP_SYSCALL;
					6'h0d: op = cpu_pkg::OP_BREAK;
					6'h20: op = cpu_pkg::OP_ADD;
					6'h21: op = cpu_pkg::OP_ADDU;
					6'h22: op = cpu_pkg::OP_SUB;
					6'h23: op = cpu_pkg::OP_SUBU;
					6'h24: op = cpu_pkg::OP_AND;
					6'h25: op = cpu_pkg::OP_OR;
					6'h26: op = cpu_pkg::OP_XOR;
					6'h27: op = cpu_pkg::OP_NOR;
					6'h2a: op = cpu_pkg::OP_SLT;
					6'h2b: op = cpu_pkg::OP_SLTU;
					6'h30: op = cpu_pkg::OP_TGE;
					6'h31: op = cpu_pkg::OP_TGEU;
					6'h32: op = cpu_pkg::OP_TLT;
					6'h33: op = cpu_pkg::OP_TLTU;
					6'h34: op = cpu_pkg::OP_TEQ;
					6'h36: op = cpu_pkg::OP_TNE;
					default: op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'h1c: begin
				if (fn == 6'h20) begin
					op = cpu_pkg::OP_CLZ;
				end else if (fn == 6'h21) begin
					op = cpu_pkg::OP_CLO;
				end
			end
			6'h01: begin
				case (iw[20:16])
					5'h08: op = cpu_pkg::OP_TGE;
					5'h09: op = cpu_pkg::OP_TGEU;
					5'h0a: op = cpu_pkg::OP_TLT;
					5'h0b: op = cpu_pkg::OP_TLTU;
					5'h0c: op = cpu_pkg::OP_TEQ;
					5'h0e: op = cpu_pkg::OP_TNE;
					default: op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'h03: op = cpu_pkg::OP_JAL;
			6'h08: op = cpu_pkg::OP_ADDI;
			6'h09: op = cpu_pkg::OP_ADDIU;
			6'h0a: op = cpu_pkg::OP_SLTI;
			6'h0b: op = cpu_pkg::OP_SLTIU;
			6'h0c: op = cpu_pkg::OP_ANDI;
			6'h0d: op = cpu_pkg::OP_ORI;
			6'h0e: op = cpu_pkg::OP_XORI;
			6'h0f: op = cpu_pkg::OP_LUI;
			6'h20: op = cpu_pkg::OP_LB;
			6'h21: op = cpu_pkg::OP_LH;
			6'h23: op = cpu_pkg::OP_LW;
			6'h24: op = cpu_pkg::OP_LBU;
			6'h25: op = cpu_pkg::OP_LHU;
			6'h28: op = cpu_pkg::OP_SB;
			6'h29: op = cpu_pkg::OP_SH;
			6'h2b: op = cpu_pkg::OP_SW;
			default: op = cpu_pkg::OP_INVALID;
		endcase

		// immediate trap forms compare against the immediate
		rt   = (opc == 6'h01) ? simm : rt_reg;
		wreg = (opc == 6'h00 || opc == 6'h1c) ? iw[15:11] : iw[20:16];
		if (op == cpu_pkg::OP_JAL) begin
			wreg = 5'd31;
		end
		if (op inside {cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW, cpu_pkg::OP_TEQ,
			cpu_pkg::OP_TNE, cpu_pkg::OP_TGE, cpu_pkg::OP_TLT, cpu_pkg::OP_TGEU,
			cpu_pkg::OP_TLTU, cpu_pkg::OP_BREAK, cpu_pkg::OP_SYSCALL, cpu_pkg::OP_INVALID}) begin
			wreg = 5'd0;
		end

		n   = 0;
		res = 32'h0;
		case (op)
			cpu_pkg::OP_LUI:   res = {iw[15:0], 16'h0};
			cpu_pkg::OP_AND:   res = rs & rt;
			cpu_pkg::OP_OR:    res = rs | rt;
			cpu_pkg::OP_XOR:   res = rs ^ rt;
			cpu_pkg::OP_NOR:   res = ~(rs | rt);
			cpu_pkg::OP_ANDI:  res = rs & {16'h0, iw[15:0]};
			cpu_pkg::OP_ORI:   res = rs | {16'h0, iw[15:0]};
			cpu_pkg::OP_XORI:  res = rs ^ {16'h0, iw[15:0]};
			cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU:   res = rs + rt;
			cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU:   res = rs - rt;
			cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU: res = rs + simm;
			cpu_pkg::OP_CLZ, cpu_pkg::OP_CLO: begin
				while (n < 32 && rs[31 - n] == (op == cpu_pkg::OP_CLO)) begin
					n++;
				end
				res = n;
			end
			cpu_pkg::OP_MOVZ, cpu_pkg::OP_MOVN:  res = rs;
			cpu_pkg::OP_JAL, cpu_pkg::OP_JALR:   res = pc + 32'd8;
			cpu_pkg::OP_SLL:   res = rt << sh;
			cpu_pkg::OP_SLLV:  res = rt << rs[4:0];
			cpu_pkg::OP_SRL:   res = rt >> sh;
			cpu_pkg::OP_SRLV:  res = rt >> rs[4:0];
			// sign bit refills the vacated top bits
			cpu_pkg::OP_SRA:   res = (rt >> sh) | (~(32'hffff_ffff >> sh) & {32{rt[31]}});
			cpu_pkg::OP_SRAV:  res = (rt >> rs[4:0]) | (~(32'hffff_ffff >> rs[4:0]) & {32{rt[31]}});
			cpu_pkg::OP_SLT:   res = {31'b0, $signed(rs) < $signed(rt)};
			cpu_pkg::OP_SLTU:  res = {31'b0, rs < rt};
			cpu_pkg::OP_SLTI:  res = {31'b0, $signed(rs) < $signed(simm)};
			cpu_pkg::OP_SLTIU: res = {31'b0, rs < simm};
			default:           res = 32'h0;
		endcase

		case (op)
			cpu_pkg::OP_ADD:  wide = {rs[31], rs} + {rt[31], rt};
			cpu_pkg::OP_SUB:  wide = {rs[31], rs} - {rt[31], rt};
			cpu_pkg::OP_ADDI: wide = {rs[31], rs} + {simm[31], simm};
			default:          wide = '0;
		endcase

		case (op)
			cpu_pkg::OP_TEQ:  trap = rs == rt;
			cpu_pkg::OP_TNE:  trap = rs != rt;
			cpu_pkg::OP_TGE:  trap = $signed(rs) >= $signed(rt);
			cpu_pkg::OP_TLT:  trap = $signed(rs) < $signed(rt);
			cpu_pkg::OP_TGEU: trap = rs >= rt;
			cpu_pkg::OP_TLTU: trap = rs < rt;
			default:          trap = 1'b0;
		endcase
		mov_fail = (op == cpu_pkg::OP_MOVZ && rt != 32'h0)
			|| (op == cpu_pkg::OP_MOVN && rt == 32'h0);

		is_ld = op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH,
			cpu_pkg::OP_LHU, cpu_pkg::OP_LW};
		is_st = op inside {cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW};
		addr  = rs + simm;
		wdata = rt;
		be    = 4'h0;
		misal = 1'b0;
		if (op inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW}) begin
			be    = 4'hf;
			misal = addr[1:0] != 2'b00;
		end else if (op inside {cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_SH}) begin
			be    = addr[1] ? 4'hc : 4'h3;
			wdata = addr[1] ? {rt[15:0], 16'h0} : rt;
			misal = addr[0];
		end else if (op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_SB}) begin
			be    = 4'h1 << addr[1:0];
			wdata = rt << (8 * addr[1:0]);
		end

		ex   = 1'b1;
		code = 5'd0;
		if (op == cpu_pkg::OP_INVALID) begin
			code = 5'd10;
		end else if (trap) begin
			code = 5'd13;
		end else if (op == cpu_pkg::OP_BREAK) begin
			code = 5'd9;
		end else if (op == cpu_pkg::OP_SYSCALL) begin
			code = 5'd8;
		end else if (wide[32] != wide[31]) begin
			code = 5'd12;
		end else if (misal) begin
			code = is_ld ? 5'd4 : 5'd5;
		end else begin
			ex = 1'b0;
		end
		wb    = wreg != 5'd0 && !mov_fail && !ex;
		rd_en = is_ld && !ex;
		wr_en = is_st && !ex;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		check_count++;
		if (exp !== got) begin
			err_count++;
			$display("[FAIL] time %0t: %s expected %h seen %h", $time, name, exp, got);
		end
	endtask

	task automatic compare_outputs();
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [4:0]  wreg;
		logic [4:0]  code;
		logic [3:0]  be;
		logic        wb;
		logic        rd_en;
		logic        wr_en;
		logic        ex;
		logic        v;
		predict(c_instr, c_pc, c_rs, c_rt, res, wb, wreg, rd_en, wr_en, addr, wdata, be, ex, code);
		v = c_valid & ~c_flush;
		check_val("out_valid", 32'(v), 32'(out_valid));
		check_val("out_wb_en", 32'(v & wb), 32'(out_wb_en));
		check_val("mem_read", 32'(v & rd_en), 32'(mem_read));
		check_val("mem_write", 32'(v & wr_en), 32'(mem_write));
		check_val("ex_valid", 32'(v & ex), 32'(ex_valid));
		if (v) begin
			check_val("out_pc", c_pc, out_pc);
			check_val("out_wb_reg", 32'(wreg), 32'(out_wb_reg));
			if (wb) begin
				check_val("out_result", res, out_result);
			end
			if (rd_en || wr_en) begin
				check_val("mem_addr", addr, mem_addr);
				check_val("mem_be", 32'(be), 32'(mem_be));
			end
			if (wr_en) begin
				check_val("mem_wdata", wdata, mem_wdata);
			end
			if (ex) begin
				check_val("ex_code", 32'(code), 32'(ex_code));
			end
			if (ex && (code == 5'd4 || code == 5'd5)) begin
				check_val("ex_badvaddr", addr, ex_badvaddr);
			end
		end
	endtask

	// outputs read here still hold the previous edge's values
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_count   = 0;
			check_count = 0;
			c_valid <= 1'b0;
			c_flush <= 1'b0;
		end else begin
			compare_outputs();
			c_valid <= in_valid;
			c_flush <= flush;
			c_pc    <= in_pc;
			c_instr <= in_instr;
			c_rs    <= rs_val;
			c_rt    <= rt_val;
		end
	end

endmodule

`default_nettype wire

/* cpu_exec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_exec_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      flush,
	input  logic                      in_valid,
	input  logic [cpu_pkg::XLEN-1:0]  in_pc,
	input  logic [cpu_pkg::XLEN-1:0]  in_instr,
	input  logic [cpu_pkg::XLEN-1:0]  rs_val,
	input  logic [cpu_pkg::XLEN-1:0]  rt_val,
	output logic                      out_valid,
	output logic [cpu_pkg::XLEN-1:0]  out_pc,
	output logic [cpu_pkg::XLEN-1:0]  out_result,
	output logic                      out_wb_en,
	output logic [cpu_pkg::REG_W-1:0] out_wb_reg,
	output logic                      mem_read,
	output logic                      mem_write,
	output logic [cpu_pkg::XLEN-1:0]  mem_addr,
	output logic [cpu_pkg::XLEN-1:0]  mem_wdata,
	output logic [3:0]                mem_be,
	output logic                      ex_valid,
	output cpu_pkg::exc_code_t        ex_code,
	output logic [cpu_pkg::XLEN-1:0]  ex_badvaddr
);

	dec_exec_if dx (.clk(clk));
	exec_res_if xr ();

	instr_decode u_decode (
		.in_valid(in_valid),
		.in_pc   (in_pc),
		.in_instr(in_instr),
		.rs_val  (rs_val),
		.rt_val  (rt_val),
		.dx      (dx.dec)
	);

	instr_exec u_exec (
		.dx(dx.exe),
		.xr(xr.exe)
	);

	exec_result u_result (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.xr         (xr.res),
		.out_valid  (out_valid),
		.out_pc     (out_pc),
		.out_result (out_result),
		.out_wb_en  (out_wb_en),
		.out_wb_reg (out_wb_reg),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_be     (mem_be),
		.ex_valid   (ex_valid),
		.ex_code    (ex_code),
		.ex_badvaddr(ex_badvaddr)
	);

endmodule

`default_nettype wire

/* exec_result.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_result (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      flush,
	exec_res_if.res                   xr,
	output logic                      out_valid,
	output logic [cpu_pkg::XLEN-1:0]  out_pc,
	output logic [cpu_pkg::XLEN-1:0]  out_result,
	output logic                      out_wb_en,
	output logic [cpu_pkg::REG_W-1:0] out_wb_reg,
	output logic                      mem_read,
	output logic                      mem_write,
	output logic [cpu_pkg::XLEN-1:0]  mem_addr,
	output logic [cpu_pkg::XLEN-1:0]  mem_wdata,
	output logic [3:0]                mem_be,
	output logic                      ex_valid,
	output cpu_pkg::exc_code_t        ex_code,
	output logic [cpu_pkg::XLEN-1:0]  ex_badvaddr
);

	logic keep, commit;

	// a faulting instruction leaves no side effects
	assign keep   = ~flush;
	assign commit = keep & ~xr.ex_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_wb_en <= 1'b0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
			ex_valid  <= 1'b0;
		end else begin
			out_valid <= xr.valid & keep;
			out_wb_en <= xr.wb_en & commit;
			mem_read  <= xr.mem_read & commit;
			mem_write <= xr.mem_write & commit;
			ex_valid  <= xr.ex_valid & keep;
		end
	end

	always_ff @(posedge clk) begin
		out_pc      <= xr.pc;
		out_result  <= xr.result;
		out_wb_reg  <= xr.wb_reg;
		mem_addr    <= xr.mem_addr;
		mem_wdata   <= xr.mem_wdata;
		mem_be      <= xr.mem_be;
		ex_code     <= xr.ex_code;
		ex_badvaddr <= xr.ex_badvaddr;
	end

	no_store_on_ex: assert property (@(posedge clk) disable iff (!arst_n)
		!(ex_valid && mem_write));

endmodule

`default_nettype wire

/* instr_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_exec (
	dec_exec_if.exe dx,
	exec_res_if.exe xr
);

	logic [cpu_pkg::XLEN-1:0] a, b, imm_sext, imm_zext;
	logic [cpu_pkg::XLEN-1:0] add_r, sub_r, addi_r, clz_cnt, clo_cnt;
	logic [cpu_pkg::XLEN-1:0] result, addr, wdata, badvaddr;
	logic [4:0]               shamt;
	logic [3:0]               be;
	logic                     ov_add, ov_sub, ov_addi, lt, ltu;
	logic                     trap, mov_fail, misaligned, ex;
	cpu_pkg::exc_code_t       code;

	assign a        = dx.rs_val;
	assign b        = dx.rt_val;
	assign shamt    = dx.instr.r.shamt;
	assign imm_sext = {{16{dx.instr.i.imm[15]}}, dx.instr.i.imm};
	assign imm_zext = {16'b0, dx.instr.i.imm};

	assign add_r  = a + b;
	assign sub_r  = a - b;
	assign addi_r = a + imm_sext;

	assign ov_add  = (a[31] == b[31]) & (a[31] ^ add_r[31]);
	assign ov_sub  = (a[31] ^ b[31]) & (a[31] ^ sub_r[31]);
	assign ov_addi = (a[31] == imm_sext[31]) & (a[31] ^ addi_r[31]);

	assign lt  = $signed(a) < $signed(b);
	assign ltu = a < b;

	count_bit count_clz (
		.bit_val(1'b0),
		.val    (a),
		.count  (clz_cnt)
	);

	count_bit count_clo (
		.bit_val(1'b1),
		.val    (a),
		.count  (clo_cnt)
	);

	always_comb begin
		case (dx.op)
			cpu_pkg::OP_LUI:   result = {dx.instr.i.imm, 16'b0};
			cpu_pkg::OP_AND:   result = a & b;
			cpu_pkg::OP_OR:    result = a | b;
			cpu_pkg::OP_XOR:   result = a ^ b;
			cpu_pkg::OP_NOR:   result = ~(a | b);
			cpu_pkg::OP_ANDI:  result = a & imm_zext;
			cpu_pkg::OP_ORI:   result = a | imm_zext;
			cpu_pkg::OP_XORI:  result = a ^ imm_zext;
			cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU:   result = add_r;
			cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU:   result = sub_r;
			cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU: result = addi_r;
			cpu_pkg::OP_CLZ:   result = clz_cnt;
			cpu_pkg::OP_CLO:   result = clo_cnt;
			cpu_pkg::OP_MOVZ, cpu_pkg::OP_MOVN:  result = a;
			// return address skips the delay slot
			cpu_pkg::OP_JAL, cpu_pkg::OP_JALR:   result = dx.pc + 32'd8;
			cpu_pkg::OP_SLL:   result = b << shamt;
			cpu_pkg::OP_SLLV:  result = b << a[4:0];
			cpu_pkg::OP_SRL:   result = b >> shamt;
			cpu_pkg::OP_SRLV:  result = b >> a[4:0];
			cpu_pkg::OP_SRA:   result = $signed(b) >>> shamt;
			cpu_pkg::OP_SRAV:  result = $signed(b) >>> a[4:0];
			cpu_pkg::OP_SLT:   result = {31'b0, lt};
			cpu_pkg::OP_SLTU:  result = {31'b0, ltu};
			cpu_pkg::OP_SLTI:  result = {31'b0, $signed(a) < $signed(imm_sext)};
			cpu_pkg::OP_SLTIU: result = {31'b0, a < imm_sext};
			default:           result = '0;
		endcase
	end

	assign mov_fail = (dx.op == cpu_pkg::OP_MOVZ && b != '0)
		|| (dx.op == cpu_pkg::OP_MOVN && b == '0);

	// effective address is used as physical
	assign addr = addi_r;

	always_comb begin
		wdata      = b;
		be         = 4'b0000;
		misaligned = 1'b0;
		case (dx.op)
			cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
				be         = 4'b1111;
				misaligned = |addr[1:0];
			end
			cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_SH: begin
				wdata      = addr[1] ? (b << 16) : b;
				be         = addr[1] ? 4'b1100 : 4'b0011;
				misaligned = addr[0];
			end
			cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_SB: begin
				wdata = b << {addr[1:0], 3'b000};
				be    = 4'b0001 << addr[1:0];
			end
			default: ;
		endcase
	end

	always_comb begin
		case (dx.op)
			cpu_pkg::OP_TEQ:  trap = (a == b);
			cpu_pkg::OP_TNE:  trap = (a != b);
			cpu_pkg::OP_TGE:  trap = ~lt;
			cpu_pkg::OP_TLT:  trap = lt;
			cpu_pkg::OP_TGEU: trap = ~ltu;
			cpu_pkg::OP_TLTU: trap = ltu;
			default:          trap = 1'b0;
		endcase
	end

	// RI first, then EX-stage causes, then address errors
	always_comb begin
		ex       = 1'b1;
		code     = '0;
		badvaddr = '0;
		if (dx.op == cpu_pkg::OP_INVALID) begin
			code = cpu_pkg::EXC_RI;
		end else if (trap) begin
			code = cpu_pkg::EXC_TR;
		end else if (dx.op == cpu_pkg::OP_BREAK) begin
			code = cpu_pkg::EXC_BP;
		end else if (dx.op == cpu_pkg::OP_SYSCALL) begin
			code = cpu_pkg::EXC_SYS;
		end else if ((dx.op == cpu_pkg::OP_ADD && ov_add) || (dx.op == cpu_pkg::OP_SUB && ov_sub)
			|| (dx.op == cpu_pkg::OP_ADDI && ov_addi)) begin
			code = cpu_pkg::EXC_OV;
		end else if (misaligned) begin
			code     = dx.is_load ? cpu_pkg::EXC_ADEL : cpu_pkg::EXC_ADES;
			badvaddr = addr;
		end else begin
			ex = 1'b0;
		end
	end

	assign xr.valid       = dx.valid;
	assign xr.pc          = dx.pc;
	assign xr.result      = result;
	assign xr.wb_en       = dx.valid && dx.wb_reg != '0 && !mov_fail;
	assign xr.wb_reg      = dx.wb_reg;
	assign xr.mem_read    = dx.valid & dx.is_load;
	assign xr.mem_write   = dx.valid & dx.is_store;
	assign xr.mem_addr    = addr;
	assign xr.mem_wdata   = wdata;
	assign xr.mem_be      = be;
	assign xr.ex_valid    = dx.valid & ex;
	assign xr.ex_code     = code;
	assign xr.ex_badvaddr = badvaddr;

	// decoder flags agree with the operation
	mem_one_strobe: assert property (@(posedge dx.clk)
		dx.valid && dx.op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH,
			cpu_pkg::OP_LHU, cpu_pkg::OP_LW, cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW}
		|-> (xr.mem_read ^ xr.mem_write));

	mem_be_set: assert property (@(posedge dx.clk)
		(xr.mem_read || xr.mem_write) |-> xr.mem_be != 4'b0000);

endmodule

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
	input  logic                     in_valid,
	input  logic [cpu_pkg::XLEN-1:0] in_pc,
	input  logic [cpu_pkg::XLEN-1:0] in_instr,
	input  logic [cpu_pkg::XLEN-1:0] rs_val,
	input  logic [cpu_pkg::XLEN-1:0] rt_val,
	dec_exec_if.dec                  dx
);

	cpu_pkg::instr_word_t      iw;
	cpu_pkg::oper_t            op;
	logic [cpu_pkg::REG_W-1:0] wb_reg;
	logic                      is_regimm;

	assign iw        = in_instr;
	assign is_regimm = (iw.i.opcode == cpu_pkg::OPC_REGIMM);

	always_comb begin
		op = cpu_pkg::OP_INVALID;
		case (iw.r.opcode)
			cpu_pkg::OPC_SPECIAL: begin
				case (iw.r.funct)
					6'h00: op = cpu_pkg::OP_SLL;
					6'h02: op = cpu_pkg::OP_SRL;
					6'h03: op = cpu_pkg::OP_SRA;
					6'h04: op = cpu_pkg::OP_SLLV;
					6'h06: op = cpu_pkg::OP_SRLV;
					6'h07: op = cpu_pkg::OP_SRAV;
					6'h09: op = cpu_pkg::OP_JALR;
					6'h0a: op = cpu_pkg::OP_MOVZ;
					6'h0b: op = cpu_pkg::OP_MOVN;
					6'h0c: op = cpu_pkg::OP_SYSCALL;
					6'h0d: op = cpu_pkg::OP_BREAK;
					6'h20: op = cpu_pkg::OP_ADD;
					6'h21: op = cpu_pkg::OP_ADDU;
					6'h22: op = cpu_pkg::OP_SUB;
					6'h23: op = cpu_pkg::OP_SUBU;
					6'h24: op = cpu_pkg::OP_AND;
					6'h25: op = cpu_pkg::OP_OR;
					6'h26: op = cpu_pkg::OP_XOR;
					6'h27: op = cpu_pkg::OP_NOR;
					6'h2a: op = cpu_pkg::OP_SLT;
					6'h2b: op = cpu_pkg::OP_SLTU;
					6'h30: op = cpu_pkg::OP_TGE;
					6'h31: op = cpu_pkg::OP_TGEU;
					6'h32: op = cpu_pkg::OP_TLT;
					6'h33: op = cpu_pkg::OP_TLTU;
					6'h34: op = cpu_pkg::OP_TEQ;
					6'h36: op = cpu_pkg::OP_TNE;
					default: op = cpu_pkg::OP_INVALID;
				endcase
			end
			cpu_pkg::OPC_SPECIAL2: begin
				case (iw.r.funct)
					6'h20: op = cpu_pkg::OP_CLZ;
					6'h21: op = cpu_pkg::OP_CLO;
					default: op = cpu_pkg::OP_INVALID;
				endcase
			end
			cpu_pkg::OPC_REGIMM: begin
				// immediate traps, selected by rt
				case (iw.i.rt)
					5'h08: op = cpu_pkg::OP_TGE;
					5'h09: op = cpu_pkg::OP_TGEU;
					5'h0a: op = cpu_pkg::OP_TLT;
					5'h0b: op = cpu_pkg::OP_TLTU;
					5'h0c: op = cpu_pkg::OP_TEQ;
					5'h0e: op = cpu_pkg::OP_TNE;
					default: op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'h03: op = cpu_pkg::OP_JAL;
			6'h08: op = cpu_pkg::OP_ADDI;
			6'h09: op = cpu_pkg::OP_ADDIU;
			6'h0a: op = cpu_pkg::OP_SLTI;
			6'h0b: op = cpu_pkg::OP_SLTIU;
			6'h0c: op = cpu_pkg::OP_ANDI;
			6'h0d: op = cpu_pkg::OP_ORI;
			6'h0e: op = cpu_pkg::OP_XORI;
			6'h0f: op = cpu_pkg::OP_LUI;
			6'h20: op = cpu_pkg::OP_LB;
			6'h21: op = cpu_pkg::OP_LH;
			6'h23: op = cpu_pkg::OP_LW;
			6'h24: op = cpu_pkg::OP_LBU;
			6'h25: op = cpu_pkg::OP_LHU;
			6'h28: op = cpu_pkg::OP_SB;
			6'h29: op = cpu_pkg::OP_SH;
			6'h2b: op = cpu_pkg::OP_SW;
			default: op = cpu_pkg::OP_INVALID;
		endcase
	end

	// destination register, zero when nothing is written
	always_comb begin
		wb_reg = iw.i.rt;
		if (iw.r.opcode == cpu_pkg::OPC_SPECIAL || iw.r.opcode == cpu_pkg::OPC_SPECIAL2) begin
			wb_reg = iw.r.rd;
		end
		case (op)
			cpu_pkg::OP_JAL: wb_reg = 5'd31;
			cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW,
			cpu_pkg::OP_TEQ, cpu_pkg::OP_TNE, cpu_pkg::OP_TGE,
			cpu_pkg::OP_TLT, cpu_pkg::OP_TGEU, cpu_pkg::OP_TLTU,
			cpu_pkg::OP_BREAK, cpu_pkg::OP_SYSCALL, cpu_pkg::OP_INVALID:
				wb_reg = '0;
			default: ;
		endcase
	end

	assign dx.valid    = in_valid;
	assign dx.pc       = in_pc;
	assign dx.instr    = iw;
	assign dx.op       = op;
	assign dx.rs_val   = rs_val;
	// regimm traps compare rs against the immediate
	assign dx.rt_val   = is_regimm ? {{16{iw.i.imm[15]}}, iw.i.imm} : rt_val;
	assign dx.wb_reg   = wb_reg;
	assign dx.is_load  = op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH,
		cpu_pkg::OP_LHU, cpu_pkg::OP_LW};
	assign dx.is_store = op inside {cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW};

endmodule

`default_nettype wire

/* count_bit.sv */
`timescale 1ns/10ps
`default_nettype none

module count_bit (
	input  logic                     bit_val,
	input  logic [cpu_pkg::XLEN-1:0] val,
	output logic [cpu_pkg::XLEN-1:0] count
);

	// highest differing bit wins since it is visited last
	always_comb begin
		count = cpu_pkg::XLEN;
		for (int i = 0; i < cpu_pkg::XLEN; i++) begin
			if (val[i] != bit_val) begin
				count = cpu_pkg::XLEN - 1 - i;
			end
		end
	end

endmodule

`default_nettype wire

/* stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dec_exec_if (
	input logic clk
);
	logic                      valid;
	logic [cpu_pkg::XLEN-1:0]  pc;
	cpu_pkg::instr_word_t      instr;
	cpu_pkg::oper_t            op;
	logic [cpu_pkg::XLEN-1:0]  rs_val;
	logic [cpu_pkg::XLEN-1:0]  rt_val;
	logic [cpu_pkg::REG_W-1:0] wb_reg;
	logic                      is_load;
	logic                      is_store;

	modport dec (
		output valid, pc, instr, op, rs_val, rt_val, wb_reg, is_load, is_store
	);
	modport exe (
		input clk, valid, pc, instr, op, rs_val, rt_val, wb_reg, is_load, is_store
	);
endinterface

interface exec_res_if;
	logic                      valid;
	logic [cpu_pkg::XLEN-1:0]  pc;
	logic [cpu_pkg::XLEN-1:0]  result;
	logic                      wb_en;
	logic [cpu_pkg::REG_W-1:0] wb_reg;
	logic                      mem_read;
	logic                      mem_write;
	logic [cpu_pkg::XLEN-1:0]  mem_addr;
	logic [cpu_pkg::XLEN-1:0]  mem_wdata;
	logic [3:0]                mem_be;
	logic                      ex_valid;
	cpu_pkg::exc_code_t        ex_code;
	logic [cpu_pkg::XLEN-1:0]  ex_badvaddr;

	modport exe (
		output valid, pc, result, wb_en, wb_reg, mem_read, mem_write,
			mem_addr, mem_wdata, mem_be, ex_valid, ex_code, ex_badvaddr
	);
	modport res (
		input valid, pc, result, wb_en, wb_reg, mem_read, mem_write,
			mem_addr, mem_wdata, mem_be, ex_valid, ex_code, ex_badvaddr
	);
endinterface

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int XLEN  = 32;
	localparam int REG_W = 5;
	localparam int EXC_W = 5;

	typedef logic [EXC_W-1:0] exc_code_t;

	// MIPS cause register codes
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;
	localparam exc_code_t EXC_TR   = 5'd13;

	typedef enum logic [5:0] {
		OP_LUI, OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
		OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN,
		OP_JAL, OP_JALR,
		OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
		OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
		OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU,
		OP_BREAK, OP_SYSCALL,
		OP_INVALID
	} oper_t;

	// one instruction word, read as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0]       opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [REG_W-1:0] rd;
			logic [4:0]       shamt;
			logic [5:0]       funct;
		} r;
		struct packed {
			logic [5:0]       opcode;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [15:0]      imm;
		} i;
	} instr_word_t;

	localparam logic [5:0] OPC_SPECIAL  = 6'h00;
	localparam logic [5:0] OPC_REGIMM   = 6'h01;
	localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

endpackage

`default_nettype wire
